// ==== tb.f ====
+incdir+source
source/sensor_logger_pkg.sv
source/fifo_rd_if.sv
source/rtc_tick_gen.sv
source/measure_ctrl.sv
source/sample_fifo.sv
source/log_channel.sv
source/readout_arbiter.sv
source/sensor_logger_top.sv
dv/adc_model.sv
dv/sensor_logger_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the sensor logger testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module sensor_logger_tb \
    -f tb.f \
    -o sim_sensor_logger

./obj_dir/sim_sensor_logger

// ==== dv/sensor_logger_tb.sv ====
`timescale 1ns/10ps
`include "sensor_logger_params.svh"

module sensor_logger_tb
    import sensor_logger_pkg::*;
();

    localparam int NCH = `LOG_NUM_CH;
    localparam int W   = `LOG_DATA_W;
    localparam int OP_TRIG = 0;
    localparam int OP_RUN  = 1;
    localparam int OP_READ = 2;
    localparam int OP_IDLE = 3;
    localparam int NUM_STEPS = 13;
    localparam int WORST_MEAS = 64;  // Longest warm-up plus conversion and sequencer overhead

    // Per-channel fields are packed with channel 3 leftmost
    typedef struct packed {
        int              op;
        int              len;
        logic            rnd;
        logic [3:0][7:0] warm;
        logic [3:0][W-1:0] smp;
        logic [3:0][3:0] exp_en;
        logic [3:0][3:0] exp_full;
        logic [3:0][3:0] exp_ovr;
    } step_t;

    logic clk;
    logic rst;
    logic log_enable;
    logic trig_now;
    logic rd_req;
    logic [NCH-1:0] adc_enable;
    logic [NCH-1:0] adc_start;
    logic [NCH-1:0] adc_ready;
    logic [NCH-1:0] adc_done;
    logic [NCH*W-1:0] adc_data;
    logic [NCH-1:0] full_alert;
    logic [NCH-1:0] overrun;
    logic      rd_valid;
    logic      rd_none;
    chan_idx_t rd_channel;
    sample_t   rd_data;

    int      warm_cfg [NCH];
    sample_t smp_cfg [NCH];
    sample_t model_data [NCH];
    step_t   steps [NUM_STEPS];
    int      seed = 21;

    // Reference model state
    sample_t   exp_q [NCH][$];
    chan_idx_t rr_mirror;
    logic      pend;
    logic      pend_none;
    chan_idx_t pend_ch;
    sample_t   pend_data;
    logic      found;
    int        idx;
    int        en_cnt [NCH];
    int        done_cnt [NCH];
    int        full_cnt [NCH];
    int        ovr_cnt [NCH];
    logic [NCH-1:0] prev_start;
    logic [NCH-1:0] prev_done;
    logic [NCH-1:0] prev_enable;

    sensor_logger_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .log_enable (log_enable),
        .trig_now   (trig_now),
        .adc_enable (adc_enable),
        .adc_start  (adc_start),
        .adc_ready  (adc_ready),
        .adc_done   (adc_done),
        .adc_data   (adc_data),
        .full_alert (full_alert),
        .overrun    (overrun),
        .rd_req     (rd_req),
        .rd_valid   (rd_valid),
        .rd_none    (rd_none),
        .rd_channel (rd_channel),
        .rd_data    (rd_data)
    );

    for (genvar g = 0; g < NCH; g++) begin : g_adc
        adc_model i_adc (
            .clk        (clk),
            .rst        (rst),
            .adc_enable (adc_enable[g]),
            .adc_start  (adc_start[g]),
            .warmup     (warm_cfg[g]),
            .sample     (smp_cfg[g]),
            .adc_ready  (adc_ready[g]),
            .adc_done   (adc_done[g]),
            .adc_data   (model_data[g])
        );
        assign adc_data[g*W +: W] = model_data[g];
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------------

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_channel(input string name, input chan_idx_t got, input chan_idx_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Monitor with reference queues and round-robin mirror
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst) begin
            if (pend && pend_none) begin
                check_flag("rd_none", rd_none, 1'b1);
                check_flag("rd_valid", rd_valid, 1'b0);
            end else if (pend) begin
                check_flag("rd_valid", rd_valid, 1'b1);
                check_flag("rd_none", rd_none, 1'b0);
                check_channel("rd_channel", rd_channel, pend_ch);
                check_sample("rd_data", rd_data, pend_data);
            end else begin
                check_flag("rd_valid", rd_valid, 1'b0);
                check_flag("rd_none", rd_none, 1'b0);
            end
            pend = 1'b0;
            if (rd_req) begin  // Reads see only samples written at earlier edges
                found = 1'b0;
                for (int i = 0; i < NCH; i++) begin
                    idx = (int'(rr_mirror) + i) % NCH;
                    if (!found && exp_q[idx].size() > 0) begin
                        found     = 1'b1;
                        pend_ch   = chan_idx_t'(idx);
                        pend_data = exp_q[idx].pop_front();
                    end
                end
                pend      = 1'b1;
                pend_none = !found;
                if (found) begin
                    rr_mirror = chan_idx_t'((int'(pend_ch) + 1) % NCH);
                end
            end
            for (int c = 0; c < NCH; c++) begin
                if (adc_done[c]) begin
                    if (exp_q[c].size() >= `LOG_FIFO_DEPTH) begin
                        stop_with_error($sformatf("channel %0d converted with a full FIFO", c));
                    end
                    exp_q[c].push_back(model_data[c]);
                    done_cnt[c]++;
                end
                if (prev_start[c] && !adc_start[c] && !prev_done[c]) begin
                    stop_with_error($sformatf("channel %0d dropped adc_start before done", c));
                end
                if (adc_enable[c] && prev_enable[c]) begin
                    stop_with_error($sformatf("channel %0d held adc_enable two cycles", c));
                end
                en_cnt[c]   += int'(adc_enable[c]);
                full_cnt[c] += int'(full_alert[c]);
                ovr_cnt[c]  += int'(overrun[c]);
            end
            prev_start  = adc_start;
            prev_done   = adc_done;
            prev_enable = adc_enable;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------

    function automatic step_t make_step(input int op, input int len, input logic rnd,
                                        input logic [31:0] warm, input logic [47:0] smp,
                                        input logic [15:0] en, input logic [15:0] full,
                                        input logic [15:0] ovr);
        step_t s;
        s.op       = op;
        s.len      = len;
        s.rnd      = rnd;
        s.warm     = warm;
        s.smp      = smp;
        s.exp_en   = en;
        s.exp_full = full;
        s.exp_ovr  = ovr;
        return s;
    endfunction

    initial begin
        steps[0]  = make_step(OP_READ, 1, 0, 0, 0, 0, 0, 0);
        steps[1]  = make_step(OP_TRIG, 1, 0, 32'h09000502, 48'h444333222111,
                              16'h1111, 16'h0000, 16'h0000);
        steps[2]  = make_step(OP_TRIG, 1, 1, 32'h01010101, 0, 16'h1111, 16'h0000, 16'h0000);
        steps[3]  = make_step(OP_READ, 3, 0, 0, 0, 0, 0, 0);
        steps[4]  = make_step(OP_TRIG, 1, 1, 32'h02070003, 0, 16'h1111, 16'h0000, 16'h0000);
        steps[5]  = make_step(OP_TRIG, 1, 1, 32'h04030201, 0, 16'h1111, 16'h1000, 16'h0000);
        steps[6]  = make_step(OP_TRIG, 1, 1, 32'h00000000, 0, 16'h0111, 16'h0111, 16'h1000);
        steps[7]  = make_step(OP_TRIG, 1, 1, 32'h00000000, 0, 16'h0000, 16'h0000, 16'h1111);
        steps[8]  = make_step(OP_READ, 18, 0, 0, 0, 0, 0, 0);
        steps[9]  = make_step(OP_RUN, 3 * `LOG_TICK_CYCLES + 30, 1, 32'h05020800,
                              0, 16'h3333, 16'h0000, 16'h0000);
        steps[10] = make_step(OP_READ, 14, 0, 0, 0, 0, 0, 0);
        steps[11] = make_step(OP_TRIG, 16, 1, 32'h28280028, 0, 16'h1121, 16'h0000, 16'h0000);
        steps[12] = make_step(OP_READ, 6, 0, 0, 0, 0, 0, 0);
    end

    // Watchdog sized from the table
    initial begin
        int limit;
        limit = 200;
        #1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            limit += steps[i].len + WORST_MEAS;
        end
        repeat (limit) @(posedge clk);
        stop_with_error("watchdog expired before the test sequence finished");
    end

    function automatic logic step_settled(input step_t s, input int base_done[NCH],
                                          input int base_ovr[NCH]);
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < NCH; c++) begin
            if (done_cnt[c] - base_done[c] != int'(s.exp_en[c])) ok = 1'b0;
            if (ovr_cnt[c] - base_ovr[c] != int'(s.exp_ovr[c])) ok = 1'b0;
        end
        return ok;
    endfunction

    initial begin
        int b_en [NCH];
        int b_done [NCH];
        int b_full [NCH];
        int b_ovr [NCH];
        step_t s;
        rst        = 1'b1;
        log_enable = 1'b0;
        trig_now   = 1'b0;
        rd_req     = 1'b0;
        rr_mirror  = '0;
        pend       = 1'b0;
        pend_none  = 1'b0;
        prev_start = '0;
        prev_done  = '0;
        prev_enable = '0;
        for (int c = 0; c < NCH; c++) begin
            warm_cfg[c] = 0;
            smp_cfg[c]  = '0;
            en_cnt[c]   = 0;
            done_cnt[c] = 0;
            full_cnt[c] = 0;
            ovr_cnt[c]  = 0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("adc_enable", |adc_enable, 1'b0);
        check_flag("adc_start", |adc_start, 1'b0);
        check_flag("full_alert", |full_alert, 1'b0);
        check_flag("overrun", |overrun, 1'b0);
        check_flag("rd_valid", rd_valid, 1'b0);
        check_flag("rd_none", rd_none, 1'b0);

        for (int i = 0; i < NUM_STEPS; i++) begin
            s = steps[i];
            for (int c = 0; c < NCH; c++) begin
                b_en[c]   = en_cnt[c];
                b_done[c] = done_cnt[c];
                b_full[c] = full_cnt[c];
                b_ovr[c]  = ovr_cnt[c];
                warm_cfg[c] <= int'(s.warm[c]);
                smp_cfg[c]  <= s.rnd ? sample_t'($random(seed)) : s.smp[c];
            end
            case (s.op)
                OP_TRIG: begin
                    trig_now <= 1'b1;
                    @(posedge clk);
                    trig_now <= 1'b0;
                    if (s.len > 1) begin  // A second trigger reaches only the idle channels
                        repeat (s.len - 1) @(posedge clk);
                        trig_now <= 1'b1;
                        @(posedge clk);
                        trig_now <= 1'b0;
                    end
                    while (!step_settled(s, b_done, b_ovr)) @(posedge clk);
                    repeat (4) @(posedge clk);  // Lets post_check and signal_full pass
                end
                OP_RUN: begin
                    log_enable <= 1'b1;
                    repeat (s.len) @(posedge clk);
                    log_enable <= 1'b0;
                    while (!step_settled(s, b_done, b_ovr)) @(posedge clk);
                    repeat (4) @(posedge clk);
                end
                OP_READ: begin
                    rd_req <= 1'b1;
                    repeat (s.len) @(posedge clk);
                    rd_req <= 1'b0;
                    repeat (3) @(posedge clk);
                end
                OP_IDLE: begin
                    repeat (s.len) @(posedge clk);
                end
                default: begin
                    stop_with_error("unknown operation in the stimulus table");
                end
            endcase
            for (int c = 0; c < NCH; c++) begin
                check_count($sformatf("adc_enable[%0d] pulses", c), en_cnt[c] - b_en[c],
                            int'(s.exp_en[c]));
                check_count($sformatf("adc_done[%0d] pulses", c), done_cnt[c] - b_done[c],
                            int'(s.exp_en[c]));
                check_count($sformatf("full_alert[%0d] pulses", c), full_cnt[c] - b_full[c],
                            int'(s.exp_full[c]));
                check_count($sformatf("overrun[%0d] pulses", c), ovr_cnt[c] - b_ovr[c],
                            int'(s.exp_ovr[c]));
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== dv/adc_model.sv ====
`timescale 1ns/10ps

module adc_model
    import sensor_logger_pkg::*;
#(
    parameter int CONV_CYCLES = 3
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    adc_enable,
    input  logic    adc_start,
    input  int      warmup,      // Cycles from enable to ready
    input  sample_t sample,      // Value returned by the next conversion
    output logic    adc_ready,
    output logic    adc_done,
    output sample_t adc_data
);

    int   warm_cnt;
    int   conv_cnt;
    logic warming;
    logic converting;

    always_ff @(posedge clk) begin
        if (rst) begin
            adc_ready  <= 1'b0;
            adc_done   <= 1'b0;
            adc_data   <= '0;
            warm_cnt   <= 0;
            conv_cnt   <= 0;
            warming    <= 1'b0;
            converting <= 1'b0;
        end else begin
            adc_done <= 1'b0;
            if (adc_enable) begin
                warming   <= 1'b1;
                warm_cnt  <= warmup;
                adc_ready <= 1'b0;
            end else if (warming) begin
                if (warm_cnt <= 0) begin
                    adc_ready <= 1'b1;
                    warming   <= 1'b0;
                end else begin
                    warm_cnt <= warm_cnt - 1;
                end
            end
            if (adc_start && adc_ready && !converting) begin
                converting <= 1'b1;
                conv_cnt   <= CONV_CYCLES - 1;
                adc_ready  <= 1'b0;  // Ready is consumed by the conversion
            end else if (converting) begin
                if (conv_cnt == 0) begin
                    adc_done   <= 1'b1;
                    adc_data   <= sample;
                    converting <= 1'b0;
                end else begin
                    conv_cnt <= conv_cnt - 1;
                end
            end
        end
    end

endmodule

// ==== source/sensor_logger_top.sv ====
`timescale 1ns/10ps
`include "sensor_logger_params.svh"

module sensor_logger_top
    import sensor_logger_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              log_enable,
    input  logic                              trig_now,

    output logic [`LOG_NUM_CH-1:0]            adc_enable,
    output logic [`LOG_NUM_CH-1:0]            adc_start,
    input  logic [`LOG_NUM_CH-1:0]            adc_ready,
    input  logic [`LOG_NUM_CH-1:0]            adc_done,
    input  logic [`LOG_NUM_CH*`LOG_DATA_W-1:0] adc_data,

    output logic [`LOG_NUM_CH-1:0]            full_alert,
    output logic [`LOG_NUM_CH-1:0]            overrun,

    input  logic                              rd_req,
    output logic                              rd_valid,
    output logic                              rd_none,
    output chan_idx_t                         rd_channel,
    output sample_t                           rd_data
);

    logic trig;  // Shared by every channel

    fifo_rd_if rd_bus [`LOG_NUM_CH] ();

    rtc_tick_gen i_tick (
        .clk        (clk),
        .rst        (rst),
        .log_enable (log_enable),
        .trig_now   (trig_now),
        .trig       (trig)
    );

    for (genvar g = 0; g < `LOG_NUM_CH; g++) begin : g_ch
        log_channel i_channel (
            .clk        (clk),
            .rst        (rst),
            .trig       (trig),
            .adc_enable (adc_enable[g]),
            .adc_start  (adc_start[g]),
            .adc_ready  (adc_ready[g]),
            .adc_done   (adc_done[g]),
            .adc_data   (adc_data[g*`LOG_DATA_W +: `LOG_DATA_W]),
            .full_alert (full_alert[g]),
            .overrun    (overrun[g]),
            .rd         (rd_bus[g])
        );
    end

    readout_arbiter i_arbiter (
        .clk        (clk),
        .rst        (rst),
        .rd_req     (rd_req),
        .ch         (rd_bus),
        .rd_valid   (rd_valid),
        .rd_none    (rd_none),
        .rd_channel (rd_channel),
        .rd_data    (rd_data)
    );

endmodule

// ==== source/readout_arbiter.sv ====
`timescale 1ns/10ps
`include "sensor_logger_params.svh"

module readout_arbiter
    import sensor_logger_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      rd_req,
    fifo_rd_if.reader ch [`LOG_NUM_CH],

    output logic      rd_valid,
    output logic      rd_none,
    output chan_idx_t rd_channel,
    output sample_t   rd_data
);

    logic [`LOG_NUM_CH-1:0] empty_vec;
    logic [`LOG_NUM_CH-1:0] rd_en_vec;
    sample_t                head [`LOG_NUM_CH];

    chan_idx_t rr_ptr;  // Channel searched first
    chan_idx_t sel;
    logic      found;

    // Interface arrays need constant indices, so flatten them here
    for (genvar g = 0; g < `LOG_NUM_CH; g++) begin : g_flat
        assign empty_vec[g] = ch[g].empty;
        assign head[g]      = ch[g].data;
        assign ch[g].rd_en  = rd_en_vec[g];
    end

    // ------------------------------------------------------------------------
    // Search from the pointer for the first channel holding a sample
    // ------------------------------------------------------------------------

    always_comb begin
        found = 1'b0;
        sel   = rr_ptr;
        for (int i = 0; i < `LOG_NUM_CH; i++) begin
            if (!found && !empty_vec[(int'(rr_ptr) + i) % `LOG_NUM_CH]) begin
                found = 1'b1;
                sel   = chan_idx_t'((int'(rr_ptr) + i) % `LOG_NUM_CH);
            end
        end
    end

    always_comb begin
        rd_en_vec = '0;
        if (rd_req && found) begin
            rd_en_vec[sel] = 1'b1;  // Pop at the same edge the head is captured
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_none  <= 1'b0;
            rr_ptr   <= '0;
        end else begin
            rd_valid <= rd_req && found;
            rd_none  <= rd_req && !found;
            if (rd_req && found) begin
                rr_ptr <= (sel == chan_idx_t'(`LOG_NUM_CH - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req && found) begin
            rd_channel <= sel;
            rd_data    <= head[sel];
        end
    end

endmodule

// ==== source/log_channel.sv ====
`timescale 1ns/10ps

module log_channel
    import sensor_logger_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    trig,

    output logic    adc_enable,
    output logic    adc_start,
    input  logic    adc_ready,
    input  logic    adc_done,
    input  sample_t adc_data,

    output logic    full_alert,
    output logic    overrun,

    fifo_rd_if.fifo rd
);

    // Write side stays inside the channel
    logic    wr_en;
    sample_t wr_data;
    logic    full;

    measure_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .trig       (trig),
        .full       (full),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .adc_enable (adc_enable),
        .adc_ready  (adc_ready),
        .adc_start  (adc_start),
        .adc_done   (adc_done),
        .adc_data   (adc_data),
        .full_alert (full_alert),
        .overrun    (overrun)
    );

    sample_fifo i_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .rd      (rd)
    );

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/10ps
`include "sensor_logger_params.svh"

module sample_fifo
    import sensor_logger_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  logic      wr_en,
    input  sample_t   wr_data,
    output logic      full,

    fifo_rd_if.fifo   rd
);

    localparam int ADDR_W = $clog2(`LOG_FIFO_DEPTH);

    sample_t         mem [`LOG_FIFO_DEPTH];
    logic [ADDR_W:0] wr_ptr;  // Extra bit tells full from empty
    logic [ADDR_W:0] rd_ptr;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Flags and head
    // ------------------------------------------------------------------------

    assign rd.empty = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                      (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign rd.data  = mem[rd_ptr[ADDR_W-1:0]];

endmodule

// ==== source/measure_ctrl.sv ====
`timescale 1ns/10ps

module measure_ctrl
    import sensor_logger_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    input  logic    trig,

    input  logic    full,
    output logic    wr_en,
    output sample_t wr_data,

    output logic    adc_enable,
    input  logic    adc_ready,
    output logic    adc_start,
    input  logic    adc_done,
    input  sample_t adc_data,

    output logic    full_alert,
    output logic    overrun
);

    meas_state_e state;
    meas_state_e state_nxt;

    // ------------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;

        case (state)
            idle: begin
                if (trig) begin
                    state_nxt = pre_check;
                end
            end

            pre_check: begin
                if (full) begin
                    state_nxt = err_overrun;
                end else begin
                    state_nxt = enable_adc;
                end
            end

            enable_adc: begin
                state_nxt = adc_warmup;
            end

            adc_warmup: begin
                if (adc_ready) begin
                    state_nxt = measure;
                end
            end

            measure: begin
                if (adc_done) begin
                    state_nxt = post_check;
                end
            end

            post_check: begin
                // Full already reflects the sample just written
                if (full) begin
                    state_nxt = signal_full;
                end else begin
                    state_nxt = idle;
                end
            end

            signal_full: begin
                state_nxt = idle;
            end

            err_overrun: begin
                state_nxt = idle;
            end

            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------

    assign adc_enable = (state == enable_adc);
    assign adc_start  = (state == measure);              // Held until done
    assign wr_en      = (state == measure) && adc_done;  // Single write per measurement
    assign wr_data    = adc_data;
    assign full_alert = (state == signal_full);
    assign overrun    = (state == err_overrun);

endmodule

// ==== source/rtc_tick_gen.sv ====
`timescale 1ns/10ps
`include "sensor_logger_params.svh"

module rtc_tick_gen (
    input  logic clk,
    input  logic rst,
    input  logic log_enable,
    input  logic trig_now,
    output logic trig
);

    localparam int CNT_W = $clog2(`LOG_TICK_CYCLES);

    logic [CNT_W-1:0] tick_cnt;
    logic             tick_done;

    assign tick_done = log_enable && (tick_cnt == CNT_W'(`LOG_TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            tick_cnt <= '0;
            trig     <= 1'b0;
        end else begin
            trig <= tick_done || trig_now;  // Registered, one cycle after the cause
            if (tick_done || trig_now || !log_enable) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/fifo_rd_if.sv ====
`timescale 1ns/10ps

interface fifo_rd_if
    import sensor_logger_pkg::*;
();

    sample_t data;   // Head entry, valid while empty is low
    logic    empty;
    logic    rd_en;  // Pops the head at the clock edge

    modport fifo (
        output data,
        output empty,
        input  rd_en
    );

    modport reader (
        input  data,
        input  empty,
        output rd_en
    );

endinterface

// ==== source/sensor_logger_pkg.sv ====
`include "sensor_logger_params.svh"

package sensor_logger_pkg;

    // Measurement sequencer states, one per step of a measurement
    typedef enum logic [2:0] {
        idle        = 3'd0,  // Waiting for trigger
        pre_check   = 3'd1,  // FIFO room check
        enable_adc  = 3'd2,
        adc_warmup  = 3'd3,
        measure     = 3'd4,  // Conversion running
        post_check  = 3'd5,
        signal_full = 3'd6,
        err_overrun = 3'd7   // Trigger with no room left
    } meas_state_e;

    // One ADC conversion result
    typedef logic [`LOG_DATA_W-1:0] sample_t;

    // Channel number
    typedef logic [$clog2(`LOG_NUM_CH)-1:0] chan_idx_t;

endpackage

// ==== source/sensor_logger_params.svh ====
`ifndef SENSOR_LOGGER_PARAMS_SVH
`define SENSOR_LOGGER_PARAMS_SVH

// Number of independent logging channels
`define LOG_NUM_CH 4

// ADC result width in bits
`define LOG_DATA_W 12

// Samples held per channel, must be a power of two
`define LOG_FIFO_DEPTH 4

// Clock cycles between periodic measurement triggers
`define LOG_TICK_CYCLES 400

`endif
